// File: rtl/memnet_cfg.svh
// network sizes for a fixed two-port ring with two cache banks
// processors must keep the top opaque bit at zero because it carries the source port
`ifndef MEMNET_CFG_SVH
`define MEMNET_CFG_SVH

// ============================================================
// topology
// ============================================================

`define MEMNET_NUM_PORTS 2

// ============================================================
// memory message fields
// ============================================================

`define MEMNET_OPAQUE_BITS 8
`define MEMNET_ADDR_BITS   32
`define MEMNET_DATA_BITS   32
`define MEMNET_LEN_BITS    2

// address bit that picks the bank in shared mode
`define MEMNET_BANK_BIT 4

// opaque bit replaced by the source port on entry
`define MEMNET_OPAQUE_SRC_BIT (`MEMNET_OPAQUE_BITS - 1)

`endif

// File: rtl/memnet_pkg.sv
// message types for the request and response rings
// port_id_t doubles as the domain id since port i always belongs to domain i
`include "memnet_cfg.svh"

package memnet_pkg;

	// port or domain number
	typedef logic [$clog2(`MEMNET_NUM_PORTS)-1:0] port_id_t;

	// ============================================================
	// memory messages
	// ============================================================

	// rw is 1 for a write
	typedef struct packed {
		logic                           rw;
		logic [`MEMNET_OPAQUE_BITS-1:0] opaque;
		logic [`MEMNET_ADDR_BITS-1:0]   addr;
		logic [`MEMNET_LEN_BITS-1:0]    len;
		logic [`MEMNET_DATA_BITS-1:0]   data;
	} mem_req_t;

	typedef struct packed {
		logic                           rw;
		logic [`MEMNET_OPAQUE_BITS-1:0] opaque;
		logic [`MEMNET_LEN_BITS-1:0]    len;
		logic                           fail;
		logic [`MEMNET_DATA_BITS-1:0]   data;
	} mem_resp_t;

	// ============================================================
	// ring messages
	// ============================================================

	// both ring structs keep dest as the routing field
	typedef struct packed {
		port_id_t dest;
		port_id_t src;
		port_id_t domain;
		mem_req_t req;
	} req_net_msg_t;

	typedef struct packed {
		port_id_t  dest;
		port_id_t  src;
		port_id_t  domain;
		mem_resp_t resp;
	} resp_net_msg_t;

endpackage

// File: rtl/mem_req_to_net.sv
// purely combinational; the opaque top bit of the request is overwritten
// mode 0 routes by the bank address bit, mode 1 keeps the request on its own bank
`timescale 1ns/1ps
`include "memnet_cfg.svh"

module mem_req_to_net
	import memnet_pkg::*;
(
	input  logic         mode,
	input  port_id_t     src,
	input  mem_req_t     mem_msg,
	output req_net_msg_t net_msg
);

	port_id_t bank;
	port_id_t dest;

	// bank selected by address in shared mode
	assign bank = mem_msg.addr[`MEMNET_BANK_BIT];

	// partitioned mode pins the request to the port's own bank
	assign dest = mode ? src : bank;

	always_comb begin
		net_msg        = '0;
		net_msg.dest   = dest;
		net_msg.src    = src;
		// each port is its own security domain
		net_msg.domain = src;
		net_msg.req    = mem_msg;

		// tag the request so the cache echo finds its way home
		net_msg.req.opaque[`MEMNET_OPAQUE_SRC_BIT] = src;
	end

endmodule

// File: rtl/mem_resp_to_net.sv
// purely combinational; dest comes from the opaque bit set by the request adapter
// in partitioned mode a cross-domain response leaves with fail set and no data
`timescale 1ns/1ps
`include "memnet_cfg.svh"

module mem_resp_to_net
	import memnet_pkg::*;
(
	input  logic          mode,
	input  port_id_t      src,
	input  mem_resp_t     mem_msg,
	input  port_id_t      domain,
	output resp_net_msg_t net_msg
);

	port_id_t dest;
	logic     blocked;

	// home port echoed back by the cache
	assign dest = mem_msg.opaque[`MEMNET_OPAQUE_SRC_BIT];

	// domain of the response must match the domain of the port it returns to
	assign blocked = mode && (domain != dest);

	always_comb begin
		net_msg        = '0;
		net_msg.dest   = dest;
		net_msg.src    = src;
		net_msg.domain = domain;
		net_msg.resp   = mem_msg;

		if (blocked) begin
			// no data may cross domains
			net_msg.resp.fail = 1'b1;
			net_msg.resp.data = '0;
		end
	end

endmodule

// File: rtl/ring_router.sv
// one node of a two-node ring; msg_t must hold a dest field of port_id_t
// eject and ring-out are registered, ring-in wins over inject for a shared register
`timescale 1ns/1ps
`include "memnet_cfg.svh"

module ring_router
	import memnet_pkg::*;
#(
	parameter type msg_t = req_net_msg_t
) (
	input  logic     clk,
	input  logic     rst,
	input  port_id_t node,

	// inject from the local adapter
	input  logic     inj_val,
	input  msg_t     inj_msg,
	output logic     inj_rdy,

	// from the previous node
	input  logic     ring_in_val,
	input  msg_t     ring_in_msg,
	output logic     ring_in_rdy,

	// to the next node
	output logic     ring_out_val,
	output msg_t     ring_out_msg,
	input  logic     ring_out_rdy,

	// eject to the local consumer
	output logic     ej_val,
	output msg_t     ej_msg,
	input  logic     ej_rdy
);

	logic ri_to_ej;
	logic inj_to_ej;
	logic ri_wants_ej;
	logic ri_wants_ro;
	logic ej_free;
	logic ro_free;
	logic ri_fire;
	logic inj_fire;
	logic ej_load_ri;
	logic ej_load_inj;
	logic ro_load_ri;
	logic ro_load_inj;

	// ============================================================
	// steering
	// ============================================================

	assign ri_to_ej  = (ring_in_msg.dest == node);
	assign inj_to_ej = (inj_msg.dest == node);

	assign ri_wants_ej = ring_in_val && ri_to_ej;
	assign ri_wants_ro = ring_in_val && !ri_to_ej;

	// a register is free when empty or draining this cycle
	assign ej_free = !ej_val || ej_rdy;
	assign ro_free = !ring_out_val || ring_out_rdy;

	// forwarding waits for an empty ring-out register
	// so rdy never closes a combinational path around the ring
	assign ring_in_rdy = ri_to_ej ? ej_free : !ring_out_val;

	// inject only takes a register that ring-in does not claim
	always_comb begin
		if (inj_to_ej) begin
			inj_rdy = ej_free && !ri_wants_ej;
		end else begin
			inj_rdy = ro_free && !ri_wants_ro;
		end
	end

	assign ri_fire  = ring_in_val && ring_in_rdy;
	assign inj_fire = inj_val && inj_rdy;

	assign ej_load_ri  = ri_fire && ri_to_ej;
	assign ej_load_inj = inj_fire && inj_to_ej;
	assign ro_load_ri  = ri_fire && !ri_to_ej;
	assign ro_load_inj = inj_fire && !inj_to_ej;

	// ============================================================
	// output registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ej_val       <= 1'b0;
			ring_out_val <= 1'b0;
		end else begin
			if (ej_load_ri || ej_load_inj) begin
				ej_val <= 1'b1;
			end else if (ej_rdy) begin
				ej_val <= 1'b0;
			end

			if (ro_load_ri || ro_load_inj) begin
				ring_out_val <= 1'b1;
			end else if (ring_out_rdy) begin
				ring_out_val <= 1'b0;
			end
		end
	end

	// payload only moves on a load, otherwise it holds
	always_ff @(posedge clk) begin
		if (ej_load_ri) begin
			ej_msg <= ring_in_msg;
		end else if (ej_load_inj) begin
			ej_msg <= inj_msg;
		end

		if (ro_load_ri) begin
			ring_out_msg <= ring_in_msg;
		end else if (ro_load_inj) begin
			ring_out_msg <= inj_msg;
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// a stalled eject keeps offering the same message
	ej_hold_a: assert property (@(posedge clk) disable iff (rst)
		ej_val && !ej_rdy |=> ej_val && $stable(ej_msg));

	// nothing leaves on the ring while reset is applied
	ro_reset_a: assert property (@(posedge clk)
		rst |=> !ring_out_val);

endmodule

// File: rtl/mem_net.sv
// two-port memory network with one ring for requests and one for responses
// mode 0 shares banks by address, mode 1 partitions by domain
// mode may only change while both rings are empty
`timescale 1ns/1ps
`include "memnet_cfg.svh"

module mem_net
	import memnet_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      mode,

	// port 0
	input  logic      req_in_val_p0,
	output logic      req_in_rdy_p0,
	input  mem_req_t  req_in_msg_p0,

	output logic      req_out_val_p0,
	input  logic      req_out_rdy_p0,
	output mem_req_t  req_out_msg_p0,
	output port_id_t  req_out_domain_p0,

	input  logic      resp_in_val_p0,
	output logic      resp_in_rdy_p0,
	input  mem_resp_t resp_in_msg_p0,
	input  port_id_t  resp_in_domain_p0,

	output logic      resp_out_val_p0,
	input  logic      resp_out_rdy_p0,
	output mem_resp_t resp_out_msg_p0,
	output port_id_t  resp_out_domain_p0,

	// port 1
	input  logic      req_in_val_p1,
	output logic      req_in_rdy_p1,
	input  mem_req_t  req_in_msg_p1,

	output logic      req_out_val_p1,
	input  logic      req_out_rdy_p1,
	output mem_req_t  req_out_msg_p1,
	output port_id_t  req_out_domain_p1,

	input  logic      resp_in_val_p1,
	output logic      resp_in_rdy_p1,
	input  mem_resp_t resp_in_msg_p1,
	input  port_id_t  resp_in_domain_p1,

	output logic      resp_out_val_p1,
	input  logic      resp_out_rdy_p1,
	output mem_resp_t resp_out_msg_p1,
	output port_id_t  resp_out_domain_p1
);

	// node ids shared by adapters and routers
	port_id_t node_p0;
	port_id_t node_p1;

	req_net_msg_t  req_net_in_p0;
	req_net_msg_t  req_net_in_p1;
	req_net_msg_t  req_net_out_p0;
	req_net_msg_t  req_net_out_p1;
	resp_net_msg_t resp_net_in_p0;
	resp_net_msg_t resp_net_in_p1;
	resp_net_msg_t resp_net_out_p0;
	resp_net_msg_t resp_net_out_p1;

	// ring links, named by direction
	logic          req_ring_val_01;
	logic          req_ring_rdy_01;
	req_net_msg_t  req_ring_msg_01;
	logic          req_ring_val_10;
	logic          req_ring_rdy_10;
	req_net_msg_t  req_ring_msg_10;
	logic          resp_ring_val_01;
	logic          resp_ring_rdy_01;
	resp_net_msg_t resp_ring_msg_01;
	logic          resp_ring_val_10;
	logic          resp_ring_rdy_10;
	resp_net_msg_t resp_ring_msg_10;

	assign node_p0 = 1'b0;
	assign node_p1 = 1'b1;

	// ============================================================
	// adapters
	// ============================================================

	mem_req_to_net u_req_adapt_p0 (
		.mode(mode), .src(node_p0), .mem_msg(req_in_msg_p0), .net_msg(req_net_in_p0)
	);

	mem_req_to_net u_req_adapt_p1 (
		.mode(mode), .src(node_p1), .mem_msg(req_in_msg_p1), .net_msg(req_net_in_p1)
	);

	mem_resp_to_net u_resp_adapt_p0 (
		.mode(mode), .src(node_p0), .mem_msg(resp_in_msg_p0),
		.domain(resp_in_domain_p0), .net_msg(resp_net_in_p0)
	);

	mem_resp_to_net u_resp_adapt_p1 (
		.mode(mode), .src(node_p1), .mem_msg(resp_in_msg_p1),
		.domain(resp_in_domain_p1), .net_msg(resp_net_in_p1)
	);

	// ============================================================
	// request ring
	// ============================================================

	ring_router #(.msg_t(req_net_msg_t)) u_req_router_p0 (
		.clk(clk), .rst(rst), .node(node_p0),
		.inj_val(req_in_val_p0), .inj_msg(req_net_in_p0), .inj_rdy(req_in_rdy_p0),
		.ring_in_val(req_ring_val_10), .ring_in_msg(req_ring_msg_10),
		.ring_in_rdy(req_ring_rdy_10),
		.ring_out_val(req_ring_val_01), .ring_out_msg(req_ring_msg_01),
		.ring_out_rdy(req_ring_rdy_01),
		.ej_val(req_out_val_p0), .ej_msg(req_net_out_p0), .ej_rdy(req_out_rdy_p0)
	);

	ring_router #(.msg_t(req_net_msg_t)) u_req_router_p1 (
		.clk(clk), .rst(rst), .node(node_p1),
		.inj_val(req_in_val_p1), .inj_msg(req_net_in_p1), .inj_rdy(req_in_rdy_p1),
		.ring_in_val(req_ring_val_01), .ring_in_msg(req_ring_msg_01),
		.ring_in_rdy(req_ring_rdy_01),
		.ring_out_val(req_ring_val_10), .ring_out_msg(req_ring_msg_10),
		.ring_out_rdy(req_ring_rdy_10),
		.ej_val(req_out_val_p1), .ej_msg(req_net_out_p1), .ej_rdy(req_out_rdy_p1)
	);

	// ============================================================
	// response ring
	// ============================================================

	ring_router #(.msg_t(resp_net_msg_t)) u_resp_router_p0 (
		.clk(clk), .rst(rst), .node(node_p0),
		.inj_val(resp_in_val_p0), .inj_msg(resp_net_in_p0), .inj_rdy(resp_in_rdy_p0),
		.ring_in_val(resp_ring_val_10), .ring_in_msg(resp_ring_msg_10),
		.ring_in_rdy(resp_ring_rdy_10),
		.ring_out_val(resp_ring_val_01), .ring_out_msg(resp_ring_msg_01),
		.ring_out_rdy(resp_ring_rdy_01),
		.ej_val(resp_out_val_p0), .ej_msg(resp_net_out_p0), .ej_rdy(resp_out_rdy_p0)
	);

	ring_router #(.msg_t(resp_net_msg_t)) u_resp_router_p1 (
		.clk(clk), .rst(rst), .node(node_p1),
		.inj_val(resp_in_val_p1), .inj_msg(resp_net_in_p1), .inj_rdy(resp_in_rdy_p1),
		.ring_in_val(resp_ring_val_01), .ring_in_msg(resp_ring_msg_01),
		.ring_in_rdy(resp_ring_rdy_01),
		.ring_out_val(resp_ring_val_10), .ring_out_msg(resp_ring_msg_10),
		.ring_out_rdy(resp_ring_rdy_10),
		.ej_val(resp_out_val_p1), .ej_msg(resp_net_out_p1), .ej_rdy(resp_out_rdy_p1)
	);

	// split ejected ring messages into port fields
	assign req_out_msg_p0     = req_net_out_p0.req;
	assign req_out_domain_p0  = req_net_out_p0.domain;
	assign req_out_msg_p1     = req_net_out_p1.req;
	assign req_out_domain_p1  = req_net_out_p1.domain;
	assign resp_out_msg_p0    = resp_net_out_p0.resp;
	assign resp_out_domain_p0 = resp_net_out_p0.domain;
	assign resp_out_msg_p1    = resp_net_out_p1.resp;
	assign resp_out_domain_p1 = resp_net_out_p1.domain;

endmodule

// File: test/tb_mem_net.sv
// random traffic in shared mode, then in partitioned mode, checked against scoreboards
// processors here keep the top opaque bit at zero since the network owns it
`timescale 1ns/1ps
`include "memnet_cfg.svh"

module tb_mem_net
	import memnet_pkg::*;
();

	localparam int NUM_REQS     = 300;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES   = 2 * 600 * 20 + RESET_CYCLES;

	logic      clk;
	logic      rst;
	logic      mode;
	logic      req_in_val[2];
	logic      req_in_rdy[2];
	mem_req_t  req_in_msg[2];
	logic      req_out_val[2];
	logic      req_out_rdy[2];
	mem_req_t  req_out_msg[2];
	port_id_t  req_out_domain[2];
	logic      resp_in_val[2];
	logic      resp_in_rdy[2];
	mem_resp_t resp_in_msg[2];
	port_id_t  resp_in_domain[2];
	logic      resp_out_val[2];
	logic      resp_out_rdy[2];
	mem_resp_t resp_out_msg[2];
	port_id_t  resp_out_domain[2];

	logic [31:0] lfsr;
	logic        req_fire[2];
	logic        resp_fire[2];
	int          req_sent[2];
	int          cycles;
	int          mismatches;
	int          other_errors;

	// scoreboards indexed by source * 2 + destination
	mem_req_t  req_sb[4][$];
	mem_resp_t resp_sb[4][$];
	port_id_t  dom_sb[4][$];
	// requests delivered to each bank and not yet answered
	mem_req_t  cache_q[2][$];

	mem_net u_mem_net (
		.clk(clk), .rst(rst), .mode(mode),
		.req_in_val_p0(req_in_val[0]), .req_in_rdy_p0(req_in_rdy[0]),
		.req_in_msg_p0(req_in_msg[0]),
		.req_out_val_p0(req_out_val[0]), .req_out_rdy_p0(req_out_rdy[0]),
		.req_out_msg_p0(req_out_msg[0]), .req_out_domain_p0(req_out_domain[0]),
		.resp_in_val_p0(resp_in_val[0]), .resp_in_rdy_p0(resp_in_rdy[0]),
		.resp_in_msg_p0(resp_in_msg[0]), .resp_in_domain_p0(resp_in_domain[0]),
		.resp_out_val_p0(resp_out_val[0]), .resp_out_rdy_p0(resp_out_rdy[0]),
		.resp_out_msg_p0(resp_out_msg[0]), .resp_out_domain_p0(resp_out_domain[0]),
		.req_in_val_p1(req_in_val[1]), .req_in_rdy_p1(req_in_rdy[1]),
		.req_in_msg_p1(req_in_msg[1]),
		.req_out_val_p1(req_out_val[1]), .req_out_rdy_p1(req_out_rdy[1]),
		.req_out_msg_p1(req_out_msg[1]), .req_out_domain_p1(req_out_domain[1]),
		.resp_in_val_p1(resp_in_val[1]), .resp_in_rdy_p1(resp_in_rdy[1]),
		.resp_in_msg_p1(resp_in_msg[1]), .resp_in_domain_p1(resp_in_domain[1]),
		.resp_out_val_p1(resp_out_val[1]), .resp_out_rdy_p1(resp_out_rdy[1]),
		.resp_out_msg_p1(resp_out_msg[1]), .resp_out_domain_p1(resp_out_domain[1])
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [79:0] got,
		input logic [79:0] exp);
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic check_idle_outputs();
		for (int p = 0; p < 2; p++) begin
			assert (!req_out_val[p]) else
				report_mismatch($sformatf("req_out_val_p%0d", p), 80'(req_out_val[p]), 80'(0));
			assert (!resp_out_val[p]) else
				report_mismatch($sformatf("resp_out_val_p%0d", p), 80'(resp_out_val[p]), 80'(0));
		end
	endtask

	// ============================================================
	// stimulus and cache model, on the falling edge
	// ============================================================

	task automatic drive_inputs();
		mem_req_t  r;
		mem_resp_t s;
		for (int p = 0; p < 2; p++) begin
			if (req_fire[p]) req_in_val[p] = 1'b0;
			if (resp_fire[p]) resp_in_val[p] = 1'b0;
			req_fire[p]  = 1'b0;
			resp_fire[p] = 1'b0;
			if (!req_in_val[p] && req_sent[p] < NUM_REQS && take_bits(2) != 0) begin
				r.rw          = 1'(take_bits(1));
				r.opaque      = 8'(take_bits(7));
				r.addr        = take_bits(32);
				r.len         = 2'(take_bits(2));
				r.data        = take_bits(32);
				req_in_msg[p] = r;
				req_in_val[p] = 1'b1;
			end
			if (!resp_in_val[p] && cache_q[p].size() > 0 && take_bits(1) != 0) begin
				r        = cache_q[p].pop_front();
				s.rw     = r.rw;
				s.opaque = r.opaque;
				s.len    = r.len;
				s.fail   = 1'b0;
				s.data   = r.rw ? 32'h0 : (r.addr ^ 32'h5a5a0000);
				resp_in_msg[p]    = s;
				resp_in_domain[p] = port_id_t'(take_bits(1));
				resp_in_val[p]    = 1'b1;
			end
			req_out_rdy[p]  = (take_bits(2) != 0);
			resp_out_rdy[p] = (take_bits(2) != 0);
		end
	endtask

	// ============================================================
	// transfers seen before the coming rising edge
	// ============================================================

	task automatic sample_transfers();
		mem_req_t  r;
		mem_req_t  e;
		mem_resp_t s;
		mem_resp_t es;
		port_id_t  ed;
		logic      hit;
		int        d;
		int        q;
		for (int p = 0; p < 2; p++) begin
			if (req_in_val[p] && req_in_rdy[p]) begin
				r = req_in_msg[p];
				r.opaque[`MEMNET_OPAQUE_SRC_BIT] = p[0];
				d = mode ? p : int'(r.addr[`MEMNET_BANK_BIT]);
				req_sb[p * 2 + d].push_back(r);
				req_sent[p]++;
				req_fire[p] = 1'b1;
			end
			if (resp_in_val[p] && resp_in_rdy[p]) begin
				s = resp_in_msg[p];
				d = int'(s.opaque[`MEMNET_OPAQUE_SRC_BIT]);
				// cross-domain responses lose their data in partitioned mode
				if (mode && resp_in_domain[p] != port_id_t'(d)) begin
					s.fail = 1'b1;
					s.data = '0;
				end
				resp_sb[p * 2 + d].push_back(s);
				dom_sb[p * 2 + d].push_back(resp_in_domain[p]);
				resp_fire[p] = 1'b1;
			end
			if (req_out_val[p] && req_out_rdy[p]) begin
				r = req_out_msg[p];
				q = int'(r.opaque[`MEMNET_OPAQUE_SRC_BIT]) * 2 + p;
				assert (req_sb[q].size() > 0) else begin
					$display("error at %0t: port %0d delivered a request nobody sent", $time, p);
					other_errors++;
				end
				if (req_sb[q].size() > 0) begin
					e = req_sb[q].pop_front();
					assert (r == e) else
						report_mismatch($sformatf("req_out_msg_p%0d", p), 80'(r), 80'(e));
					assert (req_out_domain[p] == port_id_t'(q / 2)) else
						report_mismatch($sformatf("req_out_domain_p%0d", p),
							80'(req_out_domain[p]), 80'(q / 2));
				end
				cache_q[p].push_back(r);
			end
			if (resp_out_val[p] && resp_out_rdy[p]) begin
				s = resp_out_msg[p];
				// either bank may be the sender, each bank stream stays in order
				hit = resp_sb[p].size() > 0 && resp_sb[p][0] == s &&
					dom_sb[p][0] == resp_out_domain[p];
				q = (hit || resp_sb[2 + p].size() == 0) ? p : 2 + p;
				assert (resp_sb[q].size() > 0) else begin
					$display("error at %0t: port %0d delivered a response nobody sent", $time, p);
					other_errors++;
				end
				if (resp_sb[q].size() > 0) begin
					es = resp_sb[q].pop_front();
					ed = dom_sb[q].pop_front();
					assert (s == es) else
						report_mismatch($sformatf("resp_out_msg_p%0d", p), 80'(s), 80'(es));
					assert (resp_out_domain[p] == ed) else
						report_mismatch($sformatf("resp_out_domain_p%0d", p),
							80'(resp_out_domain[p]), 80'(ed));
				end
			end
		end
	endtask

	function automatic logic all_done();
		logic done;
		done = 1'b1;
		for (int p = 0; p < 2; p++) begin
			if (req_sent[p] < NUM_REQS || req_in_val[p] || resp_in_val[p]) done = 1'b0;
			if (cache_q[p].size() != 0 || req_out_val[p] || resp_out_val[p]) done = 1'b0;
		end
		for (int q = 0; q < 4; q++) begin
			if (req_sb[q].size() != 0 || resp_sb[q].size() != 0) done = 1'b0;
		end
		return done;
	endfunction

	initial begin
		lfsr         = 32'h2e86;
		mismatches   = 0;
		other_errors = 0;
		rst          = 1'b1;
		mode         = 1'b0;
		for (int p = 0; p < 2; p++) begin
			req_in_val[p]     = 1'b0;
			req_in_msg[p]     = '0;
			req_out_rdy[p]    = 1'b0;
			resp_in_val[p]    = 1'b0;
			resp_in_msg[p]    = '0;
			resp_in_domain[p] = '0;
			resp_out_rdy[p]   = 1'b0;
			req_fire[p]       = 1'b0;
			resp_fire[p]      = 1'b0;
			req_sent[p]       = 0;
		end
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_idle_outputs();
		end
		rst = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_idle_outputs();
		end
		// shared mode first, then partitioned, draining in between
		for (int ph = 0; ph < 2; ph++) begin
			mode        = ph[0];
			req_sent[0] = 0;
			req_sent[1] = 0;
			while (!all_done()) begin
				drive_inputs();
				#1;
				sample_transfers();
				@(negedge clk);
			end
		end
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("error at %0t: run did not finish within %0d cycles", $time, MAX_CYCLES);
		other_errors++;
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+rtl
rtl/memnet_pkg.sv
rtl/mem_req_to_net.sv
rtl/mem_resp_to_net.sv
rtl/ring_router.sv
rtl/mem_net.sv
test/tb_mem_net.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator; the exit status follows the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mem_net \
	-f vlog.f -Mdir obj_dir -o tb_mem_net &&
	./obj_dir/tb_mem_net > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
